// ==== img_fb_reader.sv ====
`include "vga_consts.svh"

module img_fb_reader import vga_timing_pkg::*, vga_pixel_pkg::*; (
  input  logic     clk,
  input  logic     fb_we,
  input  fb_addr_t fb_waddr,
  input  rgb12_t   fb_wdata,
  input  coord_t   x,
  input  coord_t   y,
  input  logic     scale,
  output rgb12_t   rgb
);

  localparam int FB_DEPTH = `FB_W * `FB_H;

  rgb12_t   mem [FB_DEPTH];
  coord_t   src_x;
  coord_t   src_y;
  logic     outside;
  fb_addr_t rd_addr;
  rgb12_t   rd_data;
  logic     outside_q;

  always_ff @(posedge clk) begin
    if (fb_we && (fb_waddr < fb_addr_t'(FB_DEPTH))) begin
      mem[fb_waddr] <= fb_wdata;
    end
  end

  // scale high shows the buffer 1:1, low stretches each pixel over 2x2
  always_comb begin
    src_x   = scale ? x : (x >> 1);
    src_y   = scale ? y : (y >> 1);
    outside = (src_x >= coord_t'(`FB_W)) || (src_y >= coord_t'(`FB_H));
    rd_addr = '0;
    if (!outside) begin
      rd_addr = fb_addr_t'(src_y) * fb_addr_t'(`FB_W) + fb_addr_t'(src_x);
    end
  end

  // synchronous read, outside flag kept in step with the data
  always_ff @(posedge clk) begin
    rd_data   <= mem[rd_addr];
    outside_q <= outside;
  end

  // black around the native-size picture
  assign rgb = outside_q ? '0 : rd_data;

endmodule

// ==== pixel_out_stage.sv ====
module pixel_out_stage import vga_timing_pkg::*, vga_pixel_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  pix_src_t   src,
  input  logic       gray,
  input  logic       de,
  input  logic       h_sync_raw,
  input  logic       v_sync_raw,
  input  rgb12_t     fb_rgb,
  input  rgb12_t     pat_rgb,
  output logic       h_sync,
  output logic       v_sync,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);

  sync_t      sync_d;
  rgb12_t     pix_sel;
  logic [5:0] luma_sum;
  logic [3:0] luma;
  rgb12_t     pix_out;

  // matches the one-cycle latency of the pixel sources
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_d <= '{h_sync: 1'b1, v_sync: 1'b1, de: 1'b0};
    end else begin
      sync_d <= '{h_sync: h_sync_raw, v_sync: v_sync_raw, de: de};
    end
  end

  always_comb begin
    pix_sel  = (src == SRC_PATTERN) ? pat_rgb : fb_rgb;
    // r + 2g + b peaks at 60, divide by four
    luma_sum = 6'(pix_sel.r) + {1'b0, pix_sel.g, 1'b0} + 6'(pix_sel.b);
    luma     = luma_sum[5:2];
    pix_out  = gray ? rgb12_t'{r: luma, g: luma, b: luma} : pix_sel;
    if (!sync_d.de) begin
      pix_out = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      h_sync <= 1'b1;
      v_sync <= 1'b1;
      r      <= '0;
      g      <= '0;
      b      <= '0;
    end else begin
      h_sync <= sync_d.h_sync;
      v_sync <= sync_d.v_sync;
      r      <= pix_out.r;
      g      <= pix_out.g;
      b      <= pix_out.b;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the VGA display testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_vga_display -f vga_display_top.f; then
  echo "build failed"
  exit 1
fi

# run on past assertion failures so the testbench reaches its summary line
./obj_dir/Vtb_vga_display +verilator+error+limit+1000000 > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$log"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$log"; then
  echo "no pass message found in $log"
  exit 1
fi
exit 0

// ==== tb_vga_display.sv ====
`include "vga_consts.svh"

module tb_vga_display;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int     CLK_PERIOD   = 20;
  localparam longint FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int     N_MODES      = 5;
  // lock frame, one frame per mode, the last frame and the buffer load
  localparam longint WATCHDOG_NS  = (N_MODES + 3) * FRAME_CYCLES * CLK_PERIOD;
  localparam logic [31:0] SEED    = 32'h00b6664d;
  // gray, scale, mode
  localparam logic [2:0] MODE_LIST [N_MODES] = '{3'b001, 3'b101, 3'b000, 3'b010, 3'b110};

  logic                   clk;
  logic                   reset;
  logic [`AXI_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [`AXI_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;
  logic                   h_sync;
  logic                   v_sync;
  logic [3:0]             r;
  logic [3:0]             g;
  logic [3:0]             b;

  vga_display_top i_dut (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .h_sync  (h_sync),
    .v_sync  (v_sync),
    .r       (r),
    .g       (g),
    .b       (b)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // picture for frame buffer column col, row row
  function automatic logic [11:0] pixel_at(input int col, input int row);
    return {col[3:0], row[3:0], col[7:4] ^ row[3:0]};
  endfunction

  // aw and w together, then bready after hold cycles
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int hold);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!bvalid);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, input int hold);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // returns on the clock edge after v_sync has gone low
  task automatic wait_vsync_fall();
    do @(negedge clk); while (!v_sync);
    do @(negedge clk); while (v_sync);
    @(posedge clk);
  endtask

  initial begin
    int row;
    int col;
    int m;
    int errors;
    void'($urandom(SEED));
    reset   <= 1'b1;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    // bars on screen while the frame buffer fills
    axi_write(`REG_CTRL, 32'd1, 2);
    axi_read(`REG_CTRL, 1);
    axi_write(`REG_FB_ADDR, 32'd0, 0);
    for (row = 0; row < `FB_H; row++) begin
      for (col = 0; col < `FB_W; col++) begin
        axi_write(`REG_FB_DATA, {20'd0, pixel_at(col, row)}, 0);
      end
    end
    // mode changes land in vertical blanking
    for (m = 0; m < N_MODES; m++) begin
      wait_vsync_fall();
      axi_write(`REG_CTRL, {29'd0, MODE_LIST[m]}, $urandom_range(0, 3));
      axi_read(`REG_CTRL, $urandom_range(0, 3));
    end
    wait_vsync_fall();
    errors = i_dut.sva_inst.fail_count;
    $display("errors: %0d assertion failures", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the mode sequence finished", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== test_pattern_gen.sv ====
`include "vga_consts.svh"

module test_pattern_gen import vga_timing_pkg::*, vga_pixel_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  coord_t x,
  output rgb12_t rgb
);

  // eight equal bars across the active width
  localparam coord_t BAR_W = coord_t'(`H_ACTIVE / 8);

  logic [2:0] bar;

  // past the active width the index wraps, that region is blanked later
  assign bar = 3'(x / BAR_W);

  // bar index bits select red, green and blue fully on or off
  always_ff @(posedge clk) begin
    if (reset) begin
      rgb <= '0;
    end else begin
      rgb.r <= {4{bar[2]}};
      rgb.g <= {4{bar[1]}};
      rgb.b <= {4{bar[0]}};
    end
  end

endmodule

// ==== vga_consts.svh ====
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE 640
`define H_FP     16
`define H_SYNC   96
`define H_BP     48
// 800
`define H_TOTAL  (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// vertical raster, in lines
`define V_ACTIVE 480
`define V_FP     10
`define V_SYNC   2
`define V_BP     33
// 525
`define V_TOTAL  (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// frame buffer size in pixels
`define FB_W 320
`define FB_H 240

// axi4-lite register map
`define AXI_ADDR_W  4
`define REG_CTRL    4'h0
`define REG_FB_ADDR 4'h4
`define REG_FB_DATA 4'h8

`endif

// ==== vga_ctrl_regs.sv ====
`include "vga_consts.svh"

module vga_ctrl_regs import vga_pixel_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`AXI_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`AXI_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output logic                   fb_we,
  output fb_addr_t               fb_waddr,
  output rgb12_t                 fb_wdata,
  output pix_src_t               src,
  output logic                   scale,
  output logic                   gray
);

  localparam fb_addr_t FB_LAST = fb_addr_t'(`FB_W * `FB_H - 1);

  logic        wr_fire;
  logic        rd_fire;
  fb_addr_t    fb_ptr;
  logic [31:0] ctrl_word;
  logic [31:0] ctrl_new;
  logic [31:0] ptr_new;

  // byte lanes without a strobe keep the old value
  function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // aw and w go together, and only while no write response is pending
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;

  // bit0 mode, bit1 scale, bit2 gray
  assign ctrl_word = {29'd0, gray, scale, src == SRC_PATTERN};
  assign ctrl_new  = merge_strb(ctrl_word, wdata, wstrb);
  assign ptr_new   = merge_strb({15'd0, fb_ptr}, wdata, wstrb);

  always_ff @(posedge clk) begin
    if (reset) begin
      src    <= SRC_FB;
      scale  <= 1'b0;
      gray   <= 1'b0;
      fb_ptr <= '0;
      fb_we  <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      fb_we <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (awaddr)
          `REG_CTRL: begin
            src   <= pix_src_t'(ctrl_new[0]);
            scale <= ctrl_new[1];
            gray  <= ctrl_new[2];
          end
          `REG_FB_ADDR: begin
            fb_ptr <= ptr_new[16:0];
          end
          `REG_FB_DATA: begin
            // pixel stored at the pointer, which then moves on
            if (|wstrb[1:0]) begin
              fb_we  <= 1'b1;
              fb_ptr <= (fb_ptr == FB_LAST) ? '0 : fb_ptr + fb_addr_t'(1);
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // write data reaches the frame buffer one cycle after the handshake
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      fb_waddr <= fb_ptr;
      fb_wdata <= rgb12_t'(wdata[11:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // fb data register reads back as zero
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        `REG_CTRL:    rdata <= ctrl_word;
        `REG_FB_ADDR: rdata <= {15'd0, fb_ptr};
        default:      rdata <= '0;
      endcase
    end
  end

endmodule

// ==== vga_display_sva.sv ====
`include "vga_consts.svh"

module vga_display_sva import vga_timing_pkg::*, vga_pixel_pkg::*; (
  input logic                   clk,
  input logic                   reset,
  input logic [`AXI_ADDR_W-1:0] awaddr,
  input logic                   awvalid,
  input logic                   awready,
  input logic [31:0]            wdata,
  input logic [3:0]             wstrb,
  input logic                   wvalid,
  input logic                   wready,
  input logic [1:0]             bresp,
  input logic                   bvalid,
  input logic                   bready,
  input logic [`AXI_ADDR_W-1:0] araddr,
  input logic                   arvalid,
  input logic                   arready,
  input logic [31:0]            rdata,
  input logic [1:0]             rresp,
  input logic                   rvalid,
  input logic                   rready,
  input logic                   h_sync,
  input logic                   v_sync,
  input logic [3:0]             r,
  input logic [3:0]             g,
  input logic [3:0]             b
);
  timeunit 1ns;
  timeprecision 1ns;

  localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
  localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);
  localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FP);
  localparam coord_t HS_END   = coord_t'(`H_ACTIVE + `H_FP + `H_SYNC);
  localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FP);
  localparam coord_t VS_END   = coord_t'(`V_ACTIVE + `V_FP + `V_SYNC);
  localparam coord_t BAR_W    = coord_t'(`H_ACTIVE / 8);

  int unsigned fail_count = 0;
  logic        hs_q;
  logic        vs_q;
  logic        h_lock;
  logic        v_lock;
  coord_t      hcnt;
  coord_t      vcnt;
  coord_t      hpos;
  coord_t      vpos;
  logic        h_fall;
  logic        v_fall;
  logic        checking;
  logic        active;
  logic [2:0]  ctrl_m;
  logic        rd_ctrl;
  logic [2:0]  rd_exp;
  logic [2:0]  bar;
  rgb12_t      src_pix;
  rgb12_t      exp_pix;

  // picture loaded over axi, by frame buffer column and row
  function automatic rgb12_t fb_pixel(input coord_t col, input coord_t row);
    return {col[3:0], row[3:0], col[7:4] ^ row[3:0]};
  endfunction

  // (r + 2g + b) / 4 on every channel
  function automatic rgb12_t to_gray(input rgb12_t p);
    logic [5:0] sum;
    sum = {2'b00, p.r} + {1'b0, p.g, 1'b0} + {2'b00, p.b};
    return {sum[5:2], sum[5:2], sum[5:2]};
  endfunction

  // the first sync fall fixes the position, after that it free-runs
  assign h_fall   = hs_q && !h_sync;
  assign v_fall   = vs_q && !v_sync;
  assign hpos     = (!h_lock && h_fall) ? HS_START : hcnt;
  assign vpos     = (!v_lock && v_fall) ? VS_START : vcnt;
  assign checking = h_lock && v_lock;
  assign active   = (hpos < coord_t'(`H_ACTIVE)) && (vpos < coord_t'(`V_ACTIVE));

  always_ff @(posedge clk) begin
    if (reset) begin
      hs_q   <= 1'b1;
      vs_q   <= 1'b1;
      h_lock <= 1'b0;
      v_lock <= 1'b0;
      hcnt   <= '0;
      vcnt   <= '0;
    end else begin
      hs_q   <= h_sync;
      vs_q   <= v_sync;
      h_lock <= h_lock || h_fall;
      v_lock <= v_lock || (h_lock && v_fall);
      hcnt   <= (hpos == H_LAST) ? '0 : hpos + coord_t'(1);
      if (hpos == H_LAST) begin
        vcnt <= (vpos == V_LAST) ? '0 : vpos + coord_t'(1);
      end else begin
        vcnt <= vpos;
      end
    end
  end

  // control bits as last written: mode, scale, gray
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_m  <= '0;
      rd_ctrl <= 1'b0;
      rd_exp  <= '0;
    end else begin
      if (awvalid && awready && wvalid && wready && awaddr == `REG_CTRL && wstrb[0]) begin
        ctrl_m <= wdata[2:0];
      end
      if (arvalid && arready) begin
        rd_ctrl <= (araddr == `REG_CTRL);
        rd_exp  <= ctrl_m;
      end
    end
  end

  always_comb begin
    bar     = 3'(hpos / BAR_W);
    src_pix = '0;
    if (ctrl_m[0]) begin
      src_pix.r = bar[2] ? 4'hf : 4'h0;
      src_pix.g = bar[1] ? 4'hf : 4'h0;
      src_pix.b = bar[0] ? 4'hf : 4'h0;
    end else if (ctrl_m[1]) begin
      // native size, black beyond the buffer
      if (hpos < coord_t'(`FB_W) && vpos < coord_t'(`FB_H)) begin
        src_pix = fb_pixel(hpos, vpos);
      end
    end else begin
      src_pix = fb_pixel(hpos >> 1, vpos >> 1);
    end
    exp_pix = ctrl_m[2] ? to_gray(src_pix) : src_pix;
  end

  a_reset_idle: assert property (@(posedge clk)
      reset |=> (h_sync && v_sync && {r, g, b} == 12'h000 && !bvalid && !rvalid))
    else begin
      fail_count++;
      $error("[ERROR] %0t: outputs not idle after reset", $time);
    end

  a_h_sync: assert property (@(posedge clk) disable iff (reset || !h_lock)
      h_sync == !(hpos >= HS_START && hpos < HS_END))
    else begin
      fail_count++;
      $error("[ERROR] %0t: h_sync wrong for its position in the line", $time);
    end

  a_v_sync: assert property (@(posedge clk) disable iff (reset || !v_lock)
      v_sync == !(vpos >= VS_START && vpos < VS_END))
    else begin
      fail_count++;
      $error("[ERROR] %0t: v_sync wrong for its line in the frame", $time);
    end

  a_blank: assert property (@(posedge clk) disable iff (reset || !checking)
      !active |-> ({r, g, b} == 12'h000))
    else begin
      fail_count++;
      $error("[ERROR] %0t: colour outside the active area", $time);
    end

  a_pixel: assert property (@(posedge clk) disable iff (reset || !checking)
      active |-> ({r, g, b} == exp_pix))
    else begin
      fail_count++;
      $error("[ERROR] %0t: pixel differs from the expected colour", $time);
    end

  // aw and w are taken in the same cycle
  a_aw_w: assert property (@(posedge clk) disable iff (reset) awready == wready)
    else begin
      fail_count++;
      $error("[ERROR] %0t: awready and wready differ", $time);
    end

  a_bresp: assert property (@(posedge clk) disable iff (reset) bvalid |-> bresp == 2'b00)
    else begin
      fail_count++;
      $error("[ERROR] %0t: write response not OKAY", $time);
    end

  a_rresp: assert property (@(posedge clk) disable iff (reset) rvalid |-> rresp == 2'b00)
    else begin
      fail_count++;
      $error("[ERROR] %0t: read response not OKAY", $time);
    end

  a_b_hold: assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("[ERROR] %0t: bvalid dropped before bready", $time);
    end

  a_r_hold: assert property (@(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("[ERROR] %0t: rvalid dropped before rready", $time);
    end

  a_rd_ctrl: assert property (@(posedge clk) disable iff (reset)
      rvalid && rd_ctrl |-> rdata == {29'd0, rd_exp})
    else begin
      fail_count++;
      $error("[ERROR] %0t: control register read back wrong bits", $time);
    end

endmodule

bind vga_display_top vga_display_sva sva_inst (.*);

// ==== vga_display_top.f ====
+incdir+.
vga_timing_pkg.sv
vga_pixel_pkg.sv
vga_timing_gen.sv
vga_ctrl_regs.sv
img_fb_reader.sv
test_pattern_gen.sv
pixel_out_stage.sv
vga_display_top.sv
vga_display_sva.sv
tb_vga_display.sv

// ==== vga_display_top.sv ====
`include "vga_consts.svh"

module vga_display_top import vga_timing_pkg::*, vga_pixel_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`AXI_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`AXI_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output logic                   h_sync,
  output logic                   v_sync,
  output logic [3:0]             r,
  output logic [3:0]             g,
  output logic [3:0]             b
);

  coord_t   x;
  coord_t   y;
  logic     de;
  logic     h_sync_raw;
  logic     v_sync_raw;
  logic     fb_we;
  fb_addr_t fb_waddr;
  rgb12_t   fb_wdata;
  rgb12_t   fb_rgb;
  rgb12_t   pat_rgb;
  pix_src_t src;
  logic     scale;
  logic     gray;

  vga_timing_gen vga_timing_gen_inst (
    .clk        (clk),
    .reset      (reset),
    .x          (x),
    .y          (y),
    .de         (de),
    .h_sync_raw (h_sync_raw),
    .v_sync_raw (v_sync_raw)
  );

  vga_ctrl_regs vga_ctrl_regs_inst (
    .clk      (clk),
    .reset    (reset),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .fb_we    (fb_we),
    .fb_waddr (fb_waddr),
    .fb_wdata (fb_wdata),
    .src      (src),
    .scale    (scale),
    .gray     (gray)
  );

  img_fb_reader img_fb_reader_inst (
    .clk      (clk),
    .fb_we    (fb_we),
    .fb_waddr (fb_waddr),
    .fb_wdata (fb_wdata),
    .x        (x),
    .y        (y),
    .scale    (scale),
    .rgb      (fb_rgb)
  );

  test_pattern_gen test_pattern_gen_inst (
    .clk   (clk),
    .reset (reset),
    .x     (x),
    .rgb   (pat_rgb)
  );

  pixel_out_stage pixel_out_stage_inst (
    .clk        (clk),
    .reset      (reset),
    .src        (src),
    .gray       (gray),
    .de         (de),
    .h_sync_raw (h_sync_raw),
    .v_sync_raw (v_sync_raw),
    .fb_rgb     (fb_rgb),
    .pat_rgb    (pat_rgb),
    .h_sync     (h_sync),
    .v_sync     (v_sync),
    .r          (r),
    .g          (g),
    .b          (b)
  );

endmodule

// ==== vga_pixel_pkg.sv ====
package vga_pixel_pkg;

  // 4 bits per channel, red on top
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb12_t;

  // row * 320 + column
  typedef logic [16:0] fb_addr_t;

  // picture source feeding the output stage
  typedef enum logic {
    SRC_FB      = 1'b0,
    SRC_PATTERN = 1'b1
  } pix_src_t;

endpackage

// ==== vga_timing_gen.sv ====
`include "vga_consts.svh"

module vga_timing_gen import vga_timing_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  output coord_t x,
  output coord_t y,
  output logic   de,
  output logic   h_sync_raw,
  output logic   v_sync_raw
);

  localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
  localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);
  localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FP);
  localparam coord_t HS_END   = coord_t'(`H_ACTIVE + `H_FP + `H_SYNC);
  localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FP);
  localparam coord_t VS_END   = coord_t'(`V_ACTIVE + `V_FP + `V_SYNC);

  coord_t h_next;
  coord_t v_next;

  // next raster position
  always_comb begin
    h_next = x + coord_t'(1);
    v_next = y;
    if (x == H_LAST) begin
      h_next = '0;
      v_next = (y == V_LAST) ? '0 : y + coord_t'(1);
    end
  end

  // de and syncs decoded from the next position so they stay aligned with x and y
  always_ff @(posedge clk) begin
    if (reset) begin
      x          <= '0;
      y          <= '0;
      de         <= 1'b1;
      h_sync_raw <= 1'b1;
      v_sync_raw <= 1'b1;
    end else begin
      x          <= h_next;
      y          <= v_next;
      de         <= (h_next < coord_t'(`H_ACTIVE)) && (v_next < coord_t'(`V_ACTIVE));
      h_sync_raw <= !((h_next >= HS_START) && (h_next < HS_END));
      v_sync_raw <= !((v_next >= VS_START) && (v_next < VS_END));
    end
  end

endmodule

// ==== vga_timing_pkg.sv ====
package vga_timing_pkg;

  // raster counter or coordinate, wide enough for 0..799
  typedef logic [9:0] coord_t;

  // syncs and display-enable travelling down the pixel pipeline together
  typedef struct packed {
    logic h_sync;
    logic v_sync;
    logic de;
  } sync_t;

endpackage
